/* sdram_pkg.sv */
package sdram_pkg;

    // Field widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 16;
    localparam int ACS_W  = ADDR_W + DATA_W;

    // Address field sits above the write data in an access
    localparam int ACS_ADDR_LSB = DATA_W;

    // Default sizes
    localparam int N_PORTS    = 4;
    localparam int N_BURSTS   = 8;
    localparam int READ_DELAY = 2;                     // Beat enqueue to word at source
    localparam int MEM_WORDS  = 256;

    // Word address
    typedef logic [ADDR_W-1:0] addr_t;

    // Data word
    typedef logic [DATA_W-1:0] data_t;

    // One access with the address over the write data
    typedef logic [ACS_W-1:0] dram_access_t;

endpackage

/* fifo_sync.sv */
module fifo_sync #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 1
) (
    input  logic             CLK,
    input  logic             RESET_IN,

    input  logic [WIDTH-1:0] write_data,
    input  logic             write_req,
    output logic             write_ack,

    output logic [WIDTH-1:0] read_data,
    output logic             read_req,
    input  logic             read_ack
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  push;
    logic                  pop;

    assign write_ack = (count != (DEPTH_LOG2 + 1)'(DEPTH));   // Not full
    assign read_req  = (count != '0);                        // Not empty
    assign read_data = mem[rd_ptr];

    assign push = write_req && write_ack;
    assign pop  = read_req && read_ack;

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge CLK, posedge RESET_IN) begin
        if (RESET_IN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;                      // Wraps at power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                     // Idle or push with pop
            endcase
        end
    end

endmodule

/* sdram_fifo.sv */
module sdram_fifo #(
    parameter int N_PORTS  = sdram_pkg::N_PORTS,
    parameter int N_BURSTS = sdram_pkg::N_BURSTS
) (
    input  logic                                CLK,
    input  logic                                RESET_IN,

    // Client side
    input  logic                  [N_PORTS-1:0] src_write,
    input  sdram_pkg::dram_access_t [N_PORTS-1:0] src_acs,
    output sdram_pkg::data_t      [N_PORTS-1:0] src_data,
    input  logic                  [N_PORTS-1:0] src_req,
    output logic                  [N_PORTS-1:0] src_ack,

    // Store side
    output logic                  [N_PORTS-1:0] dst_write,
    output sdram_pkg::dram_access_t [N_PORTS-1:0] dst_acs,
    input  sdram_pkg::data_t      [N_PORTS-1:0] dst_data,
    output logic                  [N_PORTS-1:0] dst_req,
    input  logic                  [N_PORTS-1:0] dst_ack
);

    localparam int BURST_LEN = N_BURSTS + sdram_pkg::READ_DELAY;
    localparam int CNT_W     = $clog2(BURST_LEN + 1);

    for (genvar i = 0; i < N_PORTS; i++) begin : gen_port

        logic             fifo_req;
        logic             fifo_ack;
        logic [CNT_W-1:0] burst_cnt;

        fifo_sync #(
            .WIDTH      ($bits(sdram_pkg::dram_access_t) + 1),
            .DEPTH_LOG2 (1)
        ) u_queue (
            .CLK        (CLK),
            .RESET_IN   (RESET_IN),
            .write_data ({src_write[i], src_acs[i]}),
            .write_req  (fifo_req),
            .write_ack  (fifo_ack),
            .read_data  ({dst_write[i], dst_acs[i]}),
            .read_req   (dst_req[i]),
            .read_ack   (dst_ack[i])
        );

        // Store word registered to line up with the paced acks
        always_ff @(posedge CLK) begin
            src_data[i] <= dst_data[i];
        end

        // Read burst pacing counts down from BURST_LEN while the queue has space
        always_ff @(posedge CLK, posedge RESET_IN) begin
            if (RESET_IN) begin
                burst_cnt <= '0;
            end else if (!src_write[i] && src_req[i] && fifo_ack) begin
                if (burst_cnt == '0) begin
                    burst_cnt <= CNT_W'(BURST_LEN);         // New burst
                end else begin
                    burst_cnt <= burst_cnt - 1'b1;
                end
            end
        end

        assign fifo_req   = src_req[i] &&
                            (src_write[i] || burst_cnt > sdram_pkg::READ_DELAY);
        assign src_ack[i] = src_req[i] && fifo_ack &&
                            (src_write[i] || (burst_cnt != '0 && burst_cnt <= N_BURSTS));

    end : gen_port

endmodule

/* sdram_write_arbiter.sv */
module sdram_write_arbiter #(
    parameter int N_PORTS = sdram_pkg::N_PORTS
) (
    input  logic                                  CLK,
    input  logic                                  RESET_IN,

    input  logic                    [N_PORTS-1:0] dst_write,
    input  sdram_pkg::dram_access_t [N_PORTS-1:0] dst_acs,
    input  logic                    [N_PORTS-1:0] dst_req,
    output logic                    [N_PORTS-1:0] dst_ack,

    output logic                                  wr_en,
    output sdram_pkg::addr_t                      wr_addr,
    output sdram_pkg::data_t                      wr_data
);

    localparam int PTR_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [PTR_W-1:0]   rr_ptr;
    logic [PTR_W-1:0]   rr_next;
    logic [PTR_W-1:0]   winner;
    logic [N_PORTS-1:0] wr_want;
    logic [N_PORTS-1:0] grant;

    assign wr_want = dst_req & dst_write;

    // First write requester at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        grant  = '0;
        winner = rr_ptr;
        found  = 1'b0;
        for (int off = 0; off < N_PORTS; off++) begin
            idx = (int'(rr_ptr) + off) % N_PORTS;
            if (!found && wr_want[idx]) begin
                found       = 1'b1;
                grant[idx]  = 1'b1;
                winner      = PTR_W'(idx);
            end
        end
    end

    assign rr_next = (int'(winner) == N_PORTS - 1) ? '0 : winner + 1'b1;

    always_ff @(posedge CLK, posedge RESET_IN) begin
        if (RESET_IN) begin
            rr_ptr <= '0;
        end else if (wr_en) begin
            rr_ptr <= rr_next;                               // Skip past the winner
        end
    end

    assign dst_ack = (dst_req & ~dst_write) | grant;         // Reads never wait

    assign wr_en   = |grant;
    assign wr_addr = dst_acs[winner][sdram_pkg::ACS_ADDR_LSB +: sdram_pkg::ADDR_W];
    assign wr_data = dst_acs[winner][sdram_pkg::DATA_W-1:0];

endmodule

/* sdram_array.sv */
module sdram_array #(
    parameter int N_PORTS = sdram_pkg::N_PORTS
) (
    input  logic                                  CLK,

    // Single write port from the arbiter
    input  logic                                  wr_en,
    input  sdram_pkg::addr_t                      wr_addr,
    input  sdram_pkg::data_t                      wr_data,

    // One read port per client
    input  sdram_pkg::dram_access_t [N_PORTS-1:0] dst_acs,
    output sdram_pkg::data_t        [N_PORTS-1:0] dst_data
);

    sdram_pkg::data_t mem [sdram_pkg::MEM_WORDS];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    for (genvar i = 0; i < N_PORTS; i++) begin : gen_rd

        sdram_pkg::addr_t rd_addr;

        assign rd_addr     = dst_acs[i][sdram_pkg::ACS_ADDR_LSB +: sdram_pkg::ADDR_W];
        assign dst_data[i] = mem[rd_addr];                   // Combinational read

    end : gen_rd

endmodule

/* sdram_subsystem.sv */
module sdram_subsystem (
    input  logic                                            CLK,
    input  logic                                            RESET_IN,

    input  logic                    [sdram_pkg::N_PORTS-1:0] src_write,
    input  sdram_pkg::dram_access_t [sdram_pkg::N_PORTS-1:0] src_acs,
    output sdram_pkg::data_t        [sdram_pkg::N_PORTS-1:0] src_data,
    input  logic                    [sdram_pkg::N_PORTS-1:0] src_req,
    output logic                    [sdram_pkg::N_PORTS-1:0] src_ack
);

    logic                    [sdram_pkg::N_PORTS-1:0] dst_write;
    sdram_pkg::dram_access_t [sdram_pkg::N_PORTS-1:0] dst_acs;
    sdram_pkg::data_t        [sdram_pkg::N_PORTS-1:0] dst_data;
    logic                    [sdram_pkg::N_PORTS-1:0] dst_req;
    logic                    [sdram_pkg::N_PORTS-1:0] dst_ack;

    logic             wr_en;
    sdram_pkg::addr_t wr_addr;
    sdram_pkg::data_t wr_data;

    sdram_fifo u_fifo (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .src_write (src_write),
        .src_acs   (src_acs),
        .src_data  (src_data),
        .src_req   (src_req),
        .src_ack   (src_ack),
        .dst_write (dst_write),
        .dst_acs   (dst_acs),
        .dst_data  (dst_data),
        .dst_req   (dst_req),
        .dst_ack   (dst_ack)
    );

    sdram_write_arbiter u_arbiter (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .dst_write (dst_write),
        .dst_acs   (dst_acs),
        .dst_req   (dst_req),
        .dst_ack   (dst_ack),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    sdram_array u_array (
        .CLK      (CLK),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .dst_acs  (dst_acs),
        .dst_data (dst_data)
    );

endmodule

/* sdram_subsystem_properties.sv */
module sdram_subsystem_properties (
    input  logic                                            CLK,
    input  logic                                            RESET_IN,
    input  logic                    [sdram_pkg::N_PORTS-1:0] src_req,
    input  logic                    [sdram_pkg::N_PORTS-1:0] src_write,
    input  logic                    [sdram_pkg::N_PORTS-1:0] src_ack,
    input  logic                    [sdram_pkg::N_PORTS-1:0] dst_req,
    input  logic                    [sdram_pkg::N_PORTS-1:0] dst_write,
    input  logic                    [sdram_pkg::N_PORTS-1:0] dst_ack,
    input  sdram_pkg::dram_access_t [sdram_pkg::N_PORTS-1:0] dst_acs,
    input  logic                                            wr_en,
    input  sdram_pkg::addr_t                                wr_addr,
    input  sdram_pkg::data_t                                wr_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [sdram_pkg::N_PORTS-1:0] wr_grant;
    logic [sdram_pkg::N_PORTS-1:0] wr_match;

    assign wr_grant = dst_req & dst_write & dst_ack;

    for (genvar i = 0; i < sdram_pkg::N_PORTS; i++) begin : gen_match
        assign wr_match[i] = ({wr_addr, wr_data} == dst_acs[i]);   // Store write carries this head
    end : gen_match

    no_ack_in_reset: assert property (@(posedge CLK)
        (RESET_IN || $past(RESET_IN)) |-> (src_ack == '0))
        else $error("src_ack high during reset or the cycle after");

    read_head_acked: assert property (@(posedge CLK) disable iff (RESET_IN)
        ((dst_req & ~dst_write & ~dst_ack) == '0))
        else $error("read at queue head not acknowledged in the same cycle");

    one_write_grant: assert property (@(posedge CLK) disable iff (RESET_IN)
        $onehot0(wr_grant))
        else $error("more than one write grant in a cycle");

    wr_en_granted: assert property (@(posedge CLK) disable iff (RESET_IN)
        wr_en |-> ((wr_grant & wr_match) != '0))
        else $error("store write without a granted write request carrying its access");

    for (genvar i = 0; i < sdram_pkg::N_PORTS; i++) begin : gen_burst
        burst_ack_len: assert property (@(posedge CLK) disable iff (RESET_IN)
            $rose(src_req[i] && !src_write[i]) |->
                !src_ack[i] [*(sdram_pkg::READ_DELAY + 1)] ##1
                src_ack[i] [*sdram_pkg::N_BURSTS] ##1 !src_ack[i])
            else $error("read burst on port %0d gave wrong ack pattern", i);
    end : gen_burst

endmodule

bind sdram_subsystem sdram_subsystem_properties u_properties (.*);

/* tb_sdram_subsystem.sv */
module tb_sdram_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NP             = sdram_pkg::N_PORTS;
    localparam int FIRST_ACK      = 3;                       // First acked cycle of a burst
    localparam int LAST_ACK       = FIRST_ACK + sdram_pkg::N_BURSTS - 1;
    localparam int BURST_CYCLES   = LAST_ACK + 1;
    localparam int DRAIN_CYCLES   = 8;
    localparam int FILL_PER_PORT  = sdram_pkg::MEM_WORDS / NP;
    localparam int TIMEOUT_CYCLES = 4000;                    // About four times the test length

    logic                             CLK;
    logic                             RESET_IN;
    logic                    [NP-1:0] src_write;
    sdram_pkg::dram_access_t [NP-1:0] src_acs;
    sdram_pkg::data_t        [NP-1:0] src_data;
    logic                    [NP-1:0] src_req;
    logic                    [NP-1:0] src_ack;

    sdram_pkg::data_t ref_mem [sdram_pkg::MEM_WORDS];
    sdram_pkg::addr_t wq_addr [NP][FILL_PER_PORT];           // Pending writes per port
    sdram_pkg::data_t wq_data [NP][FILL_PER_PORT];
    int               wq_len  [NP];
    sdram_pkg::addr_t rd_base [NP][2];                       // Burst start per port and burst
    logic [31:0]      lcg_state;
    int               cycle_cnt;

    sdram_subsystem UUT (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .src_write (src_write),
        .src_acs   (src_acs),
        .src_data  (src_data),
        .src_req   (src_req),
        .src_ack   (src_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic sdram_pkg::data_t random_word();
        return sdram_pkg::data_t'(next_random() >> 16);      // Upper bits mix better
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge CLK);
    endtask

    task automatic clear_write_queues();
        for (int p = 0; p < NP; p++) begin
            wq_len[p] = 0;
        end
    endtask

    // Drives all queued writes, each port advancing on its own ack
    task automatic run_writes(output int n_cycles);
        int            idx [NP];
        logic [NP-1:0] ack;
        logic [NP-1:0] busy;
        busy     = '0;
        n_cycles = 0;
        @(posedge CLK);
        for (int p = 0; p < NP; p++) begin
            idx[p] = 0;
            if (wq_len[p] > 0) begin
                busy[p]      = 1'b1;
                src_req[p]   <= 1'b1;
                src_write[p] <= 1'b1;
                src_acs[p]   <= {wq_addr[p][0], wq_data[p][0]};
            end
        end
        while (busy != '0) begin
            @(negedge CLK);
            ack = src_ack;
            n_cycles++;
            @(posedge CLK);
            for (int p = 0; p < NP; p++) begin
                if (busy[p] && ack[p]) begin
                    ref_mem[wq_addr[p][idx[p]]] = wq_data[p][idx[p]];
                    idx[p]++;
                    if (idx[p] < wq_len[p]) begin
                        src_acs[p] <= {wq_addr[p][idx[p]], wq_data[p][idx[p]]};
                    end else begin
                        busy[p]    = 1'b0;
                        src_req[p] <= 1'b0;
                    end
                end
            end
        end
    endtask

    // Runs n_bursts back-to-back read bursts on every port in mask
    task automatic read_bursts(input logic [NP-1:0] mask, input int n_bursts);
        int               b;
        int               l;
        logic [NP-1:0]    exp_ack;
        sdram_pkg::data_t exp_data;
        for (int c = 0; c < BURST_CYCLES * n_bursts; c++) begin
            b = c / BURST_CYCLES;
            l = c % BURST_CYCLES;
            @(posedge CLK);
            for (int p = 0; p < NP; p++) begin
                if (mask[p]) begin
                    src_req[p]   <= 1'b1;
                    src_write[p] <= 1'b0;
                    src_acs[p]   <= {sdram_pkg::addr_t'(rd_base[p][b] + ((l > 0) ? l - 1 : 0)),
                                     sdram_pkg::data_t'(0)};
                end
            end
            @(negedge CLK);
            exp_ack = (l >= FIRST_ACK) ? mask : '0;
            assert (src_ack == exp_ack) else begin
                $display("CHECK FAILED at %0t: burst cycle %0d src_ack %b, expected %b",
                         $time, l, src_ack, exp_ack);
                $display("SOME TESTS FAILED");
                $fatal(1);
            end
            for (int p = 0; p < NP; p++) begin
                if (exp_ack[p]) begin
                    exp_data = ref_mem[sdram_pkg::addr_t'(rd_base[p][b] + l - FIRST_ACK)];
                    assert (src_data[p] === exp_data) else begin
                        $display("CHECK FAILED at %0t: port %0d beat %0d data %h, expected %h",
                                 $time, p, l - FIRST_ACK, src_data[p], exp_data);
                        $display("SOME TESTS FAILED");
                        $fatal(1);
                    end
                end
            end
        end
        @(posedge CLK);
        for (int p = 0; p < NP; p++) begin
            if (mask[p]) begin
                src_req[p] <= 1'b0;
            end
        end
    endtask

    task automatic check_reset_idle();
        repeat (4) begin
            @(negedge CLK);
            assert (src_ack == '0) else begin
                $display("CHECK FAILED at %0t: src_ack %b with no request", $time, src_ack);
                $display("SOME TESTS FAILED");
                $fatal(1);
            end
        end
    endtask

    // Every word gets a known value, so any later burst can be checked
    task automatic fill_store();
        int n;
        for (int p = 0; p < NP; p++) begin
            wq_len[p] = FILL_PER_PORT;
            for (int k = 0; k < FILL_PER_PORT; k++) begin
                wq_addr[p][k] = sdram_pkg::addr_t'(p * FILL_PER_PORT + k);
                wq_data[p][k] = random_word();
            end
        end
        run_writes(n);
        idle_cycles(DRAIN_CYCLES);
    endtask

    task automatic test_single_port();
        int               n;
        sdram_pkg::addr_t base;
        base = sdram_pkg::addr_t'(next_random());
        clear_write_queues();
        wq_len[0] = 8;
        for (int k = 0; k < 8; k++) begin
            wq_addr[0][k] = base + sdram_pkg::addr_t'(k);
            wq_data[0][k] = random_word();
        end
        run_writes(n);
        assert (n == 8) else begin
            $display("CHECK FAILED at %0t: 8 writes took %0d cycles, expected 8", $time, n);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
        idle_cycles(DRAIN_CYCLES);
        rd_base[0][0] = base;
        read_bursts(NP'(1), 1);
    endtask

    task automatic test_write_contention();
        int n;
        clear_write_queues();
        for (int p = 0; p < NP; p++) begin
            wq_len[p]     = 6;
            rd_base[p][0] = sdram_pkg::addr_t'(8'h80 + p * 8);
            for (int k = 0; k < 6; k++) begin
                wq_addr[p][k] = rd_base[p][0] + sdram_pkg::addr_t'(k);
                wq_data[p][k] = random_word();
            end
        end
        run_writes(n);
        idle_cycles(DRAIN_CYCLES);
        read_bursts('1, 1);
    endtask

    task automatic test_parallel_reads();
        for (int p = 0; p < NP; p++) begin
            rd_base[p][0] = sdram_pkg::addr_t'(8'h10 + p * 8'h20);
        end
        read_bursts('1, 1);
    endtask

    task automatic test_back_to_back();
        rd_base[2][0] = 8'h30;
        rd_base[2][1] = 8'hA0;
        read_bursts(NP'(4), 2);                              // Port 2 holds its request
    endtask

    task automatic test_random_traffic();
        int n;
        int wp;
        int rp;
        for (int round = 0; round < 20; round++) begin
            clear_write_queues();
            wp         = int'(next_random() % NP);
            wq_len[wp] = 1 + int'(next_random() % 8);
            for (int k = 0; k < wq_len[wp]; k++) begin
                wq_addr[wp][k] = sdram_pkg::addr_t'(next_random() >> 8);
                wq_data[wp][k] = random_word();
            end
            run_writes(n);
            idle_cycles(DRAIN_CYCLES);
            rp             = int'(next_random() % NP);
            rd_base[rp][0] = sdram_pkg::addr_t'(next_random() >> 8);
            read_bursts(NP'(1) << rp, 1);
        end
    endtask

    initial begin
        RESET_IN  = 1'b1;
        src_req   = '0;
        src_write = '0;
        src_acs   = '0;
        lcg_state = 32'h2518b46c;
        repeat (10) @(posedge CLK);
        RESET_IN <= 1'b0;
        check_reset_idle();
        fill_store();
        test_single_port();
        test_write_contention();
        test_parallel_reads();
        test_back_to_back();
        test_random_traffic();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sdram_subsystem.f */
sdram_pkg.sv
fifo_sync.sv
sdram_fifo.sv
sdram_write_arbiter.sv
sdram_array.sv
sdram_subsystem.sv
sdram_subsystem_properties.sv
tb_sdram_subsystem.sv

/* Bender.yml */
package:
  name: sdram_subsystem

sources:
  - files:
      - sdram_pkg.sv
      - fifo_sync.sv
      - sdram_fifo.sv
      - sdram_write_arbiter.sv
      - sdram_array.sv
      - sdram_subsystem.sv
  - target: test
    files:
      - sdram_subsystem_properties.sv
      - tb_sdram_subsystem.sv
